/* source/fifo_ctrl_defines.svh */
// fifo controller build constants
// depth, address width and the static almost-full / almost-empty thresholds
// one set of values shared by the package and the testbench

`ifndef FIFO_CTRL_DEFINES_SVH
`define FIFO_CTRL_DEFINES_SVH

// ------------------------------------------------------------
// memory geometry
// ------------------------------------------------------------

// words held by the external ram, 4 .. 1024, power of two not required
`define FIFO_DEPTH 16

// ceil(log2(FIFO_DEPTH)), keep in step with the depth
`define FIFO_AW 4

// ------------------------------------------------------------
// static thresholds
// ------------------------------------------------------------

// afull set when level >= this
`define FIFO_AFULL_VAL 12

// aempty set when level <= this
`define FIFO_AEMPTY_VAL 4

`endif

/* source/fifo_ctrl_pkg.sv */
// fifo controller types
// fill level and memory address words used across the controller
// plus the level and address limits derived from the build constants

`default_nettype none

package fifo_ctrl_pkg;

`include "fifo_ctrl_defines.svh"

   // ------------------------------------------------------------
   // types
   // ------------------------------------------------------------

   // 0 .. FIFO_DEPTH, one extra bit over the address
   typedef logic [`FIFO_AW:0]   level_t;

   // ram address, wraps at FIFO_DEPTH-1
   typedef logic [`FIFO_AW-1:0] addr_t;

   // ------------------------------------------------------------
   // limits
   // ------------------------------------------------------------

   localparam level_t LVL_FULL   = level_t'(`FIFO_DEPTH);      // every word used
   localparam level_t LVL_AFULL  = level_t'(`FIFO_AFULL_VAL);  // afull threshold
   localparam level_t LVL_AEMPTY = level_t'(`FIFO_AEMPTY_VAL); // aempty threshold

   // last valid address, pointer wraps after it
   localparam addr_t  ADDR_LAST  = addr_t'(`FIFO_DEPTH - 1);

endpackage

`default_nettype wire

/* source/fill_counter.sv */
// fifo fill counter
// up on a lone accepted write, down on a lone accepted read
// offers the next level to the flag logic

`default_nettype none

module fill_counter (
   input  logic                  pos_clk,
   input  logic                  aresetn,
   input  logic                  wr_ok_i,       // accepted write
   input  logic                  rd_ok_i,       // accepted read
   output fifo_ctrl_pkg::level_t level_next_o,  // level after this edge
   output fifo_ctrl_pkg::level_t count_o        // registered level
);
   import fifo_ctrl_pkg::*;

   // ------------------------------------------------------------
   // next level
   // ------------------------------------------------------------
   always_comb begin
      unique case ({wr_ok_i, rd_ok_i})
         2'b10:   level_next_o = count_o + level_t'(1);  // write only
         2'b01:   level_next_o = count_o - level_t'(1);  // read only
         default: level_next_o = count_o;                // both cancel, or idle
      endcase
   end

   // ------------------------------------------------------------
   // level register
   // ------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         count_o <= '0;             // empty after reset
      end else begin
         count_o <= level_next_o;
      end
   end

   // gating in flag_gen keeps this within 0 .. LVL_FULL,
   // so no saturation is needed here

endmodule

`default_nettype wire

/* source/flag_gen.sv */
// fifo status flags and access gating
// requests are gated by the registered full and empty flags
// all four flags register from the next fill level

`default_nettype none

module flag_gen (
   input  logic                  pos_clk,
   input  logic                  aresetn,
   input  logic                  we_i,          // raw write request
   input  logic                  re_i,          // raw read request
   input  fifo_ctrl_pkg::level_t level_next_i,  // from fill_counter
   output logic                  wr_ok_o,       // write accepted
   output logic                  rd_ok_o,       // read accepted
   output logic                  full_o,
   output logic                  afull_o,
   output logic                  empty_o,
   output logic                  aempty_o
);
   import fifo_ctrl_pkg::*;

   // ------------------------------------------------------------
   // acceptance
   // ------------------------------------------------------------

   // only place full/empty gate the requests
   assign wr_ok_o = we_i & ~full_o;
   assign rd_ok_o = re_i & ~empty_o;

   // ------------------------------------------------------------
   // flag registers
   // ------------------------------------------------------------
   // flags follow the level one edge after the access,
   // same edge as count_o so they always agree with it

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         full_o   <= 1'b0;
         afull_o  <= 1'b0;
         empty_o  <= 1'b1;    // level 0 after reset
         aempty_o <= 1'b1;
      end else begin
         full_o   <= (level_next_i == LVL_FULL);
         afull_o  <= (level_next_i >= LVL_AFULL);   // at or above
         empty_o  <= (level_next_i == '0);
         aempty_o <= (level_next_i <= LVL_AEMPTY);  // at or below
      end
   end

   // ------------------------------------------------------------
   // checks
   // ------------------------------------------------------------

   // full and empty are exclusive, needs the counter to stay in range
   property p_full_empty_excl;
      @(posedge pos_clk) disable iff (!aresetn)
         !(full_o && empty_o);
   endproperty

   // a strobe past a set flag would push the next level out of 0 .. LVL_FULL
   // underflow wraps to all ones, also above LVL_FULL
   property p_no_strobe_on_flag;
      @(posedge pos_clk) disable iff (!aresetn)
         level_next_i <= LVL_FULL;
   endproperty

   a_full_empty_excl : assert property (p_full_empty_excl)
      else $error("flag_gen: full and empty set together");

   a_no_strobe_on_flag : assert property (p_no_strobe_on_flag)
      else $error("flag_gen: strobe while full or empty");

endmodule

`default_nettype wire

/* source/addr_gen.sv */
// fifo ram address pointers
// write and read pointers step on their strobes
// each wraps from FIFO_DEPTH-1 back to zero, any depth

`default_nettype none

module addr_gen (
   input  logic                 pos_clk,
   input  logic                 aresetn,
   input  logic                 wr_ok_i,   // accepted write
   input  logic                 rd_ok_i,   // accepted read
   output fifo_ctrl_pkg::addr_t waddr_o,   // current write pointer
   output fifo_ctrl_pkg::addr_t raddr_o    // current read pointer
);
   import fifo_ctrl_pkg::*;

   // step one address, wrap on the last word
   function automatic addr_t ptr_inc(input addr_t ptr);
      if (ptr == ADDR_LAST) begin
         return '0;
      end
      return ptr + addr_t'(1);
   endfunction

   // ------------------------------------------------------------
   // pointer registers
   // ------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         waddr_o <= '0;
         raddr_o <= '0;
      end else begin
         if (wr_ok_i) begin
            waddr_o <= ptr_inc(waddr_o);  // next free slot
         end
         if (rd_ok_i) begin
            raddr_o <= ptr_inc(raddr_o);  // next word out
         end
      end
   end

   // ------------------------------------------------------------
   // checks
   // ------------------------------------------------------------

   // non power of two depth leaves unused codes, never hit them
   a_ptr_in_range : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
         (waddr_o <= ADDR_LAST) && (raddr_o <= ADDR_LAST))
      else $error("addr_gen: pointer beyond last ram word");

endmodule

`default_nettype wire

/* source/xfer_status.sv */
// fifo transfer status
// wack and dvld one cycle after an accepted write or read
// overflow and underflow one cycle after a refused request

`default_nettype none

module xfer_status (
   input  logic pos_clk,
   input  logic aresetn,
   input  logic we_i,         // raw write request
   input  logic re_i,         // raw read request
   input  logic wr_ok_i,      // write accepted
   input  logic rd_ok_i,      // read accepted
   output logic wack_o,
   output logic dvld_o,
   output logic overflow_o,
   output logic underflow_o
);

   logic wr_refused;   // request seen, strobe withheld
   logic rd_refused;

   // ------------------------------------------------------------
   // refusal
   // ------------------------------------------------------------

   // a request without its strobe, flags are not looked at here
   assign wr_refused = we_i & ~wr_ok_i;
   assign rd_refused = re_i & ~rd_ok_i;

   // ------------------------------------------------------------
   // status registers
   // ------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_o      <= 1'b0;
         dvld_o      <= 1'b0;
         overflow_o  <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         wack_o      <= wr_ok_i;      // one pulse per accepted write
         dvld_o      <= rd_ok_i;      // ram data valid next cycle
         overflow_o  <= wr_refused;   // write while full
         underflow_o <= rd_refused;   // read while empty
      end
   end

   // ------------------------------------------------------------
   // checks
   // ------------------------------------------------------------

   // a request is either done or refused, never both
   a_status_excl : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
         !(wack_o && overflow_o) && !(dvld_o && underflow_o))
      else $error("xfer_status: done and refused in the same cycle");

endmodule

`default_nettype wire

/* source/fifo_ctrl_top.sv */
// synchronous fifo controller for an external ram
// single fill counter drives full/afull/empty/aempty and count
// also drives ram addresses and enables, wack/dvld and overflow/underflow

`default_nettype none

module fifo_ctrl_top (
   input  logic                  pos_clk,
   input  logic                  aresetn,
   input  logic                  we_i,         // write request
   input  logic                  re_i,         // read request
   output logic                  full_o,
   output logic                  afull_o,
   output logic                  empty_o,
   output logic                  aempty_o,
   output fifo_ctrl_pkg::level_t count_o,      // fill level
   output logic                  wack_o,       // write done, 1 cycle late
   output logic                  dvld_o,       // read done, 1 cycle late
   output logic                  overflow_o,   // write refused
   output logic                  underflow_o,  // read refused
   output fifo_ctrl_pkg::addr_t  mem_waddr_o,
   output logic                  mem_we_o,
   output fifo_ctrl_pkg::addr_t  mem_raddr_o,
   output logic                  mem_re_o
);
   import fifo_ctrl_pkg::*;

   logic   wr_ok;        // accepted write this cycle
   logic   rd_ok;        // accepted read this cycle
   level_t level_next;   // level after this cycle

   // ------------------------------------------------------------
   // access gating and status flags
   // ------------------------------------------------------------
   flag_gen u_flag_gen (
      .pos_clk      (pos_clk),
      .aresetn      (aresetn),
      .we_i         (we_i),
      .re_i         (re_i),
      .level_next_i (level_next),
      .wr_ok_o      (wr_ok),
      .rd_ok_o      (rd_ok),
      .full_o       (full_o),
      .afull_o      (afull_o),
      .empty_o      (empty_o),
      .aempty_o     (aempty_o)
   );

   // fill level
   fill_counter u_fill_counter (
      .pos_clk      (pos_clk),
      .aresetn      (aresetn),
      .wr_ok_i      (wr_ok),
      .rd_ok_i      (rd_ok),
      .level_next_o (level_next),
      .count_o      (count_o)
   );

   // ram pointers
   addr_gen u_addr_gen (
      .pos_clk (pos_clk),
      .aresetn (aresetn),
      .wr_ok_i (wr_ok),
      .rd_ok_i (rd_ok),
      .waddr_o (mem_waddr_o),
      .raddr_o (mem_raddr_o)
   );

   // ------------------------------------------------------------
   // transfer status
   // ------------------------------------------------------------
   xfer_status u_xfer_status (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we_i),
      .re_i        (re_i),
      .wr_ok_i     (wr_ok),
      .rd_ok_i     (rd_ok),
      .wack_o      (wack_o),
      .dvld_o      (dvld_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o)
   );

   // ram strobes are the acceptance strobes, same cycle
   assign mem_we_o = wr_ok;
   assign mem_re_o = rd_ok;

endmodule

`default_nettype wire

/* bench/fifo_ctrl_checker.sv */
// fifo controller checker
// keeps its own level and pointer model from the fifo rules
// concurrent assertions compare every dut output each cycle and count errors

`default_nettype none

`include "fifo_ctrl_defines.svh"

module fifo_ctrl_checker (
   input  logic                  pos_clk,
   input  logic                  aresetn,
   input  logic                  we_i,
   input  logic                  re_i,
   input  fifo_ctrl_pkg::level_t count_o,
   input  logic                  full_o,
   input  logic                  afull_o,
   input  logic                  empty_o,
   input  logic                  aempty_o,
   input  logic                  wack_o,
   input  logic                  dvld_o,
   input  logic                  overflow_o,
   input  logic                  underflow_o,
   input  fifo_ctrl_pkg::addr_t  mem_waddr_o,
   input  logic                  mem_we_o,
   input  fifo_ctrl_pkg::addr_t  mem_raddr_o,
   input  logic                  mem_re_o,
   output int                    errs_o        // mismatches seen so far
);
   timeunit 1ns;
   timeprecision 100ps;

   int   errs = 0;
   int   m_level;    // words held
   int   m_wptr;     // next write slot
   int   m_rptr;     // next read slot
   logic m_wack;
   logic m_dvld;
   logic m_ovf;
   logic m_unf;
   logic m_full;
   logic m_afull;
   logic m_empty;
   logic m_aempty;
   logic m_wr_ok;
   logic m_rd_ok;

   assign errs_o = errs;

   // ------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------
   assign m_full   = (m_level == `FIFO_DEPTH);
   assign m_afull  = (m_level >= `FIFO_AFULL_VAL);
   assign m_empty  = (m_level == 0);
   assign m_aempty = (m_level <= `FIFO_AEMPTY_VAL);
   assign m_wr_ok  = we_i && !m_full;    // accepted unless full
   assign m_rd_ok  = re_i && !m_empty;   // accepted unless empty

   always @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         m_level <= 0;
         m_wptr  <= 0;
         m_rptr  <= 0;
         m_wack  <= 1'b0;
         m_dvld  <= 1'b0;
         m_ovf   <= 1'b0;
         m_unf   <= 1'b0;
      end else begin
         m_level <= m_level + (m_wr_ok ? 1 : 0) - (m_rd_ok ? 1 : 0);  // both cancel
         if (m_wr_ok) begin
            m_wptr <= (m_wptr + 1) % `FIFO_DEPTH;
         end
         if (m_rd_ok) begin
            m_rptr <= (m_rptr + 1) % `FIFO_DEPTH;
         end
         m_wack <= m_wr_ok;
         m_dvld <= m_rd_ok;
         m_ovf  <= we_i && m_full;     // write while full
         m_unf  <= re_i && m_empty;    // read while empty
      end
   end

   // ------------------------------------------------------------
   // comparisons
   // ------------------------------------------------------------
   task automatic report_mismatch(input string name, input int expected, input int actual);
      errs++;
      $display("Fail t=%0t %s expected %0d got %0d", $time, name, expected, actual);
   endtask

   // preponed samples, so model and dut are seen from the same side of the edge
   property p_match(exp_v, act_v);
      @(posedge pos_clk) disable iff (!aresetn)
         act_v == exp_v;
   endproperty

   a_count : assert property (p_match(m_level, count_o))
      else report_mismatch("count_o", $sampled(m_level), $sampled(count_o));
   a_full : assert property (p_match(m_full, full_o))
      else report_mismatch("full_o", $sampled(m_full), $sampled(full_o));
   a_afull : assert property (p_match(m_afull, afull_o))
      else report_mismatch("afull_o", $sampled(m_afull), $sampled(afull_o));
   a_empty : assert property (p_match(m_empty, empty_o))
      else report_mismatch("empty_o", $sampled(m_empty), $sampled(empty_o));
   a_aempty : assert property (p_match(m_aempty, aempty_o))
      else report_mismatch("aempty_o", $sampled(m_aempty), $sampled(aempty_o));
   a_waddr : assert property (p_match(m_wptr, mem_waddr_o))
      else report_mismatch("mem_waddr_o", $sampled(m_wptr), $sampled(mem_waddr_o));
   a_raddr : assert property (p_match(m_rptr, mem_raddr_o))
      else report_mismatch("mem_raddr_o", $sampled(m_rptr), $sampled(mem_raddr_o));
   a_mem_we : assert property (p_match(m_wr_ok, mem_we_o))
      else report_mismatch("mem_we_o", $sampled(m_wr_ok), $sampled(mem_we_o));
   a_mem_re : assert property (p_match(m_rd_ok, mem_re_o))
      else report_mismatch("mem_re_o", $sampled(m_rd_ok), $sampled(mem_re_o));
   a_wack : assert property (p_match(m_wack, wack_o))
      else report_mismatch("wack_o", $sampled(m_wack), $sampled(wack_o));
   a_dvld : assert property (p_match(m_dvld, dvld_o))
      else report_mismatch("dvld_o", $sampled(m_dvld), $sampled(dvld_o));
   a_ovf : assert property (p_match(m_ovf, overflow_o))
      else report_mismatch("overflow_o", $sampled(m_ovf), $sampled(overflow_o));
   a_unf : assert property (p_match(m_unf, underflow_o))
      else report_mismatch("underflow_o", $sampled(m_unf), $sampled(underflow_o));

endmodule

`default_nettype wire

/* bench/fifo_ctrl_tb.sv */
// fifo controller testbench
// fill to full, drain to empty, then seeded random mixed traffic
// the checker compares every cycle against its own model

`default_nettype none

`include "fifo_ctrl_defines.svh"

module fifo_ctrl_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import fifo_ctrl_pkg::*;

   localparam int WAIT_LIMIT  = 4 * `FIFO_DEPTH;  // cycles allowed per flag wait
   localparam int RAND_CYCLES = 640;              // ten bias swaps

   logic   pos_clk = 1'b0;
   logic   aresetn;
   logic   we_i;
   logic   re_i;
   logic   full_o;
   logic   afull_o;
   logic   empty_o;
   logic   aempty_o;
   level_t count_o;
   logic   wack_o;
   logic   dvld_o;
   logic   overflow_o;
   logic   underflow_o;
   addr_t  mem_waddr_o;
   logic   mem_we_o;
   addr_t  mem_raddr_o;
   logic   mem_re_o;
   int     check_errs;          // from the checker
   int     timeouts = 0;
   int     seed = 32'heba6_fe54;
   bit     ok;

   always #20 pos_clk = ~pos_clk;  // 40 ns period

   fifo_ctrl_top dut (.*);

   fifo_ctrl_checker u_checker (.*, .errs_o(check_errs));

   // ------------------------------------------------------------
   // stimulus tasks
   // ------------------------------------------------------------

   // keep requesting until full (writes) or empty (reads), bounded
   task automatic stream_until_flag(input logic wr, input logic rd, output bit reached);
      int n;
      reached = 1'b0;
      for (n = 0; n < WAIT_LIMIT; n++) begin
         @(negedge pos_clk);
         if (wr ? full_o : empty_o) begin
            reached = 1'b1;
            break;
         end
         we_i = wr;
         re_i = rd;
      end
      if (!reached) begin
         timeouts++;
         $display("timeout at %0t waiting for %s", $time, wr ? "full_o" : "empty_o");
      end
   endtask

   task automatic hold_requests(input logic wr, input logic rd, input int cycles);
      repeat (cycles) begin
         @(negedge pos_clk);
         we_i = wr;
         re_i = rd;
      end
   endtask

   // bias swaps every 64 cycles so both ends get hit
   task automatic random_traffic();
      int i;
      int r;
      for (i = 0; i < RAND_CYCLES; i++) begin
         @(negedge pos_clk);
         r = $random(seed);
         if (i[6]) begin
            we_i = (r[1:0] == 2'b00);   // mostly reads
            re_i = (r[3:2] != 2'b00);
         end else begin
            we_i = (r[1:0] != 2'b00);   // mostly writes
            re_i = (r[3:2] == 2'b00);
         end
      end
   endtask

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------
   initial begin
      aresetn = 1'b0;
      we_i    = 1'b0;
      re_i    = 1'b0;
      repeat (2) @(posedge pos_clk);
      @(negedge pos_clk);
      aresetn = 1'b1;

      stream_until_flag(1'b1, 1'b0, ok);   // fill
      if (ok) begin
         hold_requests(1'b1, 1'b0, 3);      // overflow attempts
         hold_requests(1'b1, 1'b1, 2);      // read frees a slot, first write refused
         stream_until_flag(1'b0, 1'b1, ok); // drain
      end
      if (ok) begin
         hold_requests(1'b0, 1'b1, 3);      // underflow attempts
         hold_requests(1'b1, 1'b1, 2);      // first read refused at empty
         random_traffic();
      end
      hold_requests(1'b0, 1'b0, 3);         // idle, last responses settle

      $display("closing report: %0d check errors, %0d timeouts", check_errs, timeouts);
      if (check_errs == 0 && timeouts == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
+incdir+source
source/fifo_ctrl_pkg.sv
source/fill_counter.sv
source/flag_gen.sv
source/addr_gen.sv
source/xfer_status.sv
source/fifo_ctrl_top.sv
bench/fifo_ctrl_checker.sv
bench/fifo_ctrl_tb.sv
